/* all.f */
+incdir+source
source/noc_axi_pkg.sv
source/noc_flit_pkg.sv
source/noc_spill_reg.sv
source/noc_req_packer.sv
source/noc_wormhole_arb.sv
source/noc_rsp_unpacker.sv
source/noc_axi_chimney.sv
test/tb_noc_axi_chimney.sv

/* run.sh */
#!/bin/sh
# Build and run the AXI to NoC interface testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_noc_axi_chimney \
  -f all.f \
  -o sim_tb

./obj_dir/sim_tb

/* source/noc_axi_chimney.sv */
////////////////////////////////////////////////////////////////////////////
// Manager-side AXI to NoC network interface for one tile.
// AW, W and AR leave as request flits on one NoC output; response
// flits return as AXI B and R. Connect node_id_i to this tile's node.
////////////////////////////////////////////////////////////////////////////

`include "noc_config.svh"

module noc_axi_chimney (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic [`NOC_NODE_ID_W-1:0] node_id_i,
  // AXI requests
  input  logic                      aw_valid_i,
  input  logic [`NOC_ADDR_W-1:0]    aw_addr_i,
  input  logic [`NOC_ID_W-1:0]      aw_id_i,
  input  logic [`NOC_LEN_W-1:0]     aw_len_i,
  output logic                      aw_ready_o,
  input  logic                      w_valid_i,
  input  logic [`NOC_DATA_W-1:0]    w_data_i,
  input  logic [`NOC_STRB_W-1:0]    w_strb_i,
  input  logic                      w_last_i,
  output logic                      w_ready_o,
  input  logic                      ar_valid_i,
  input  logic [`NOC_ADDR_W-1:0]    ar_addr_i,
  input  logic [`NOC_ID_W-1:0]      ar_id_i,
  input  logic [`NOC_LEN_W-1:0]     ar_len_i,
  output logic                      ar_ready_o,
  // AXI responses
  output logic                      b_valid_o,
  output logic [`NOC_ID_W-1:0]      b_id_o,
  output noc_axi_pkg::resp_t        b_resp_o,
  input  logic                      b_ready_i,
  output logic                      r_valid_o,
  output logic [`NOC_ID_W-1:0]      r_id_o,
  output logic [`NOC_DATA_W-1:0]    r_data_o,
  output noc_axi_pkg::resp_t        r_resp_o,
  output logic                      r_last_o,
  input  logic                      r_ready_i,
  // NoC links
  output logic                      req_valid_o,
  output noc_flit_pkg::req_flit_t   req_flit_o,
  input  logic                      req_ready_i,
  input  logic                      rsp_valid_i,
  input  noc_flit_pkg::rsp_flit_t   rsp_flit_i,
  output logic                      rsp_ready_o
);

  noc_axi_pkg::aw_chan_t         aw_in, aw_cut;
  noc_axi_pkg::ar_chan_t         ar_in, ar_cut;
  noc_axi_pkg::w_chan_t          w_in;
  noc_axi_pkg::b_chan_t          b_out;
  noc_axi_pkg::r_chan_t          r_out;
  noc_flit_pkg::req_flit_t [1:0] arb_flit;
  noc_flit_pkg::rsp_flit_t       rsp_cut;
  logic                          aw_cut_valid, aw_cut_ready;
  logic                          ar_cut_valid, ar_cut_ready;
  logic [1:0]                    arb_valid, arb_gnt;
  logic                          rsp_cut_valid, rsp_cut_ready;

  assign aw_in = '{addr: aw_addr_i, id: aw_id_i, len: aw_len_i};
  assign ar_in = '{addr: ar_addr_i, id: ar_id_i, len: ar_len_i};
  assign w_in  = '{data: w_data_i, strb: w_strb_i, last: w_last_i};

  ////////////////////////////////////////////////////////////////////////////
  // Request path

  noc_spill_reg #(
    .T (noc_axi_pkg::aw_chan_t)
  ) aw_cut0 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (aw_valid_i),
    .data_i  (aw_in),
    .ready_o (aw_ready_o),
    .valid_o (aw_cut_valid),
    .data_o  (aw_cut),
    .ready_i (aw_cut_ready)
  );

  noc_spill_reg #(
    .T (noc_axi_pkg::ar_chan_t)
  ) ar_cut0 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (ar_valid_i),
    .data_i  (ar_in),
    .ready_o (ar_ready_o),
    .valid_o (ar_cut_valid),
    .data_o  (ar_cut),
    .ready_i (ar_cut_ready)
  );

  // Source 0 is the write side, source 1 the read side
  noc_req_packer packer0 (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .node_id_i  (node_id_i),
    .aw_valid_i (aw_cut_valid),
    .aw_i       (aw_cut),
    .aw_ready_o (aw_cut_ready),
    .w_valid_i  (w_valid_i),
    .w_i        (w_in),
    .w_ready_o  (w_ready_o),
    .ar_valid_i (ar_cut_valid),
    .ar_i       (ar_cut),
    .ar_ready_o (ar_cut_ready),
    .wr_valid_o (arb_valid[0]),
    .wr_flit_o  (arb_flit[0]),
    .wr_gnt_i   (arb_gnt[0]),
    .rd_valid_o (arb_valid[1]),
    .rd_flit_o  (arb_flit[1]),
    .rd_gnt_i   (arb_gnt[1])
  );

  noc_wormhole_arb arb0 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (arb_valid),
    .flit_i  (arb_flit),
    .gnt_o   (arb_gnt),
    .valid_o (req_valid_o),
    .flit_o  (req_flit_o),
    .ready_i (req_ready_i)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Response path

  noc_spill_reg #(
    .T (noc_flit_pkg::rsp_flit_t)
  ) rsp_cut0 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (rsp_valid_i),
    .data_i  (rsp_flit_i),
    .ready_o (rsp_ready_o),
    .valid_o (rsp_cut_valid),
    .data_o  (rsp_cut),
    .ready_i (rsp_cut_ready)
  );

  noc_rsp_unpacker unpacker0 (
    .rsp_valid_i (rsp_cut_valid),
    .rsp_flit_i  (rsp_cut),
    .rsp_ready_o (rsp_cut_ready),
    .b_valid_o   (b_valid_o),
    .b_o         (b_out),
    .b_ready_i   (b_ready_i),
    .r_valid_o   (r_valid_o),
    .r_o         (r_out),
    .r_ready_i   (r_ready_i)
  );

  assign b_id_o   = b_out.id;
  assign b_resp_o = b_out.resp;
  assign r_id_o   = r_out.id;
  assign r_data_o = r_out.data;
  assign r_resp_o = r_out.resp;
  assign r_last_o = r_out.last;

endmodule

/* source/noc_axi_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// AXI channel payload types for the network interface.
// Referenced by scoped names, e.g. noc_axi_pkg::aw_chan_t.
////////////////////////////////////////////////////////////////////////////

`include "noc_config.svh"

package noc_axi_pkg;

  typedef logic [1:0] resp_t;

  typedef struct packed {
    logic [`NOC_ADDR_W-1:0] addr;
    logic [`NOC_ID_W-1:0]   id;
    logic [`NOC_LEN_W-1:0]  len;
  } aw_chan_t;

  // Read address has the same layout as write address
  typedef aw_chan_t ar_chan_t;

  typedef struct packed {
    logic [`NOC_DATA_W-1:0] data;
    logic [`NOC_STRB_W-1:0] strb;
    logic                   last;
  } w_chan_t;

  typedef struct packed {
    logic [`NOC_ID_W-1:0] id;
    resp_t                resp;
  } b_chan_t;

  typedef struct packed {
    logic [`NOC_ID_W-1:0]   id;
    logic [`NOC_DATA_W-1:0] data;
    resp_t                  resp;
    logic                   last;
  } r_chan_t;

endpackage

/* source/noc_config.svh */
////////////////////////////////////////////////////////////////////////////
// Widths shared by the AXI-to-NoC network interface RTL.
// Include this header wherever a width below is needed.
////////////////////////////////////////////////////////////////////////////

`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

// AXI side
`define NOC_ADDR_W 32
`define NOC_ID_W 4
`define NOC_DATA_W 32
`define NOC_STRB_W (`NOC_DATA_W / 8)
`define NOC_LEN_W 8

// NoC side, node IDs sit in the top address bits
`define NOC_NODE_ID_W 4

`endif

/* source/noc_flit_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Flit header and flit types carried over the NoC links.
// Payload widths follow the AXI channel structs of noc_axi_pkg.
////////////////////////////////////////////////////////////////////////////

`include "noc_config.svh"

package noc_flit_pkg;

  typedef enum logic [2:0] {
    CH_AW = 3'd0,
    CH_W  = 3'd1,
    CH_AR = 3'd2,
    CH_B  = 3'd3,
    CH_R  = 3'd4
  } axi_ch_e;

  typedef struct packed {
    logic [`NOC_NODE_ID_W-1:0] dst_id;
    logic [`NOC_NODE_ID_W-1:0] src_id;
    logic                      last;
    axi_ch_e                   ch;
  } hdr_t;

  // Request payload fits the wider of AW and W
  localparam int unsigned REQ_PAYLOAD_W =
    ($bits(noc_axi_pkg::aw_chan_t) > $bits(noc_axi_pkg::w_chan_t)) ?
    $bits(noc_axi_pkg::aw_chan_t) : $bits(noc_axi_pkg::w_chan_t);

  localparam int unsigned RSP_PAYLOAD_W = $bits(noc_axi_pkg::r_chan_t);

  typedef logic [REQ_PAYLOAD_W-1:0] req_payload_t;
  typedef logic [RSP_PAYLOAD_W-1:0] rsp_payload_t;

  typedef struct packed {
    hdr_t         hdr;
    req_payload_t payload;
  } req_flit_t;

  // B responses use the low bits of the payload
  typedef struct packed {
    hdr_t         hdr;
    rsp_payload_t payload;
  } rsp_flit_t;

endpackage

/* source/noc_req_packer.sv */
////////////////////////////////////////////////////////////////////////////
// Builds request flits from AXI AW, W and AR.
// Tracks the AW/W phase of a write burst and decodes the destination
// node from the top address bits. Grants from the arbiter act as ready.
////////////////////////////////////////////////////////////////////////////

`include "noc_config.svh"

module noc_req_packer (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic [`NOC_NODE_ID_W-1:0] node_id_i,
  input  logic                      aw_valid_i,
  input  noc_axi_pkg::aw_chan_t     aw_i,
  output logic                      aw_ready_o,
  input  logic                      w_valid_i,
  input  noc_axi_pkg::w_chan_t      w_i,
  output logic                      w_ready_o,
  input  logic                      ar_valid_i,
  input  noc_axi_pkg::ar_chan_t     ar_i,
  output logic                      ar_ready_o,
  output logic                      wr_valid_o,
  output noc_flit_pkg::req_flit_t   wr_flit_o,
  input  logic                      wr_gnt_i,
  output logic                      rd_valid_o,
  output noc_flit_pkg::req_flit_t   rd_flit_o,
  input  logic                      rd_gnt_i
);

  typedef enum logic {PH_AW, PH_W} wr_phase_e;

  wr_phase_e                 phase_q;
  logic [`NOC_NODE_ID_W-1:0] aw_dst, ar_dst, w_dst_q;
  logic                      aw_hs, w_hs;

  assign aw_dst = aw_i.addr[`NOC_ADDR_W-1 -: `NOC_NODE_ID_W];
  assign ar_dst = ar_i.addr[`NOC_ADDR_W-1 -: `NOC_NODE_ID_W];

  ////////////////////////////////////////////////////////////////////////////
  // Write phase

  assign wr_valid_o = (phase_q == PH_AW) ? aw_valid_i : w_valid_i;
  assign aw_ready_o = wr_gnt_i && (phase_q == PH_AW);
  assign w_ready_o  = wr_gnt_i && (phase_q == PH_W);

  assign aw_hs = aw_valid_i && aw_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      phase_q <= PH_AW;
    end else if (aw_hs) begin
      phase_q <= PH_W;
    end else if (w_hs && w_i.last) begin
      phase_q <= PH_AW;
    end
  end

  // W beats follow the node picked at AW
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      w_dst_q <= aw_dst;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Flit building

  always_comb begin
    wr_flit_o.hdr.src_id = node_id_i;
    if (phase_q == PH_AW) begin
      wr_flit_o.hdr.dst_id = aw_dst;
      wr_flit_o.hdr.last   = 1'b0;
      wr_flit_o.hdr.ch     = noc_flit_pkg::CH_AW;
      wr_flit_o.payload    = noc_flit_pkg::req_payload_t'(aw_i);
    end else begin
      wr_flit_o.hdr.dst_id = w_dst_q;
      wr_flit_o.hdr.last   = w_i.last;
      wr_flit_o.hdr.ch     = noc_flit_pkg::CH_W;
      wr_flit_o.payload    = noc_flit_pkg::req_payload_t'(w_i);
    end
  end

  // Reads are single-flit packets
  always_comb begin
    rd_flit_o.hdr.dst_id = ar_dst;
    rd_flit_o.hdr.src_id = node_id_i;
    rd_flit_o.hdr.last   = 1'b1;
    rd_flit_o.hdr.ch     = noc_flit_pkg::CH_AR;
    rd_flit_o.payload    = noc_flit_pkg::req_payload_t'(ar_i);
  end

  assign rd_valid_o = ar_valid_i;
  assign ar_ready_o = rd_gnt_i;

  // Wormhole lock keeps reads out of a running write burst
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    phase_q == PH_W |-> !rd_gnt_i)
    else $error("read source granted in the middle of a write burst");

endmodule

/* source/noc_rsp_unpacker.sv */
////////////////////////////////////////////////////////////////////////////
// Steers response flits to the AXI B or R channel by header channel
// code and returns the ready of the selected channel.
////////////////////////////////////////////////////////////////////////////

module noc_rsp_unpacker (
  input  logic                    rsp_valid_i,
  input  noc_flit_pkg::rsp_flit_t rsp_flit_i,
  output logic                    rsp_ready_o,
  output logic                    b_valid_o,
  output noc_axi_pkg::b_chan_t    b_o,
  input  logic                    b_ready_i,
  output logic                    r_valid_o,
  output noc_axi_pkg::r_chan_t    r_o,
  input  logic                    r_ready_i
);

  logic is_b, is_r;

  assign is_b = (rsp_flit_i.hdr.ch == noc_flit_pkg::CH_B);
  assign is_r = (rsp_flit_i.hdr.ch == noc_flit_pkg::CH_R);

  assign b_o = rsp_flit_i.payload[$bits(noc_axi_pkg::b_chan_t)-1:0];
  assign r_o = rsp_flit_i.payload;

  assign b_valid_o = rsp_valid_i && is_b;
  assign r_valid_o = rsp_valid_i && is_r;

  // Stray codes are consumed so the link cannot hang
  always_comb begin
    if (is_b) begin
      rsp_ready_o = b_ready_i;
    end else if (is_r) begin
      rsp_ready_o = r_ready_i;
    end else begin
      rsp_ready_o = 1'b1;
    end
  end

  always_comb begin
    if (rsp_valid_i) begin
      assert (is_b || is_r)
        else $error("request channel code on the response input");
    end
  end

endmodule

/* source/noc_spill_reg.sv */
////////////////////////////////////////////////////////////////////////////
// Two-slot valid/ready register slice for any payload type T.
// Cuts both the forward path and the ready path of a channel.
////////////////////////////////////////////////////////////////////////////

module noc_spill_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  input  T     data_i,
  output logic ready_o,
  output logic valid_o,
  output T     data_o,
  input  logic ready_i
);

  logic a_full_q, b_full_q;
  T     a_data_q, b_data_q;
  logic live_q;
  logic a_fill, a_drain, b_fill, b_drain;

  // Slot A takes input, slot B holds the spilled item under back-pressure
  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  assign ready_o = live_q && !(a_full_q && b_full_q);
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      live_q   <= 1'b0;
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // Output must not move while the consumer stalls
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o))
    else $error("spill register output changed under back-pressure");

endmodule

/* source/noc_wormhole_arb.sv */
////////////////////////////////////////////////////////////////////////////
// Round-robin arbiter over two request flit sources.
// Once a source gets a flit out, it keeps the output until a
// flit with the last flag is accepted.
////////////////////////////////////////////////////////////////////////////

module noc_wormhole_arb (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic [1:0]                    valid_i,
  input  noc_flit_pkg::req_flit_t [1:0] flit_i,
  output logic [1:0]                    gnt_o,
  output logic                          valid_o,
  output noc_flit_pkg::req_flit_t       flit_o,
  input  logic                          ready_i
);

  logic sel;
  logic rr_q;
  logic locked_q, lock_idx_q;

  always_comb begin
    if (locked_q) begin
      sel = lock_idx_q;
    end else if (valid_i[0] && valid_i[1]) begin
      // Favour the source not served last
      sel = ~rr_q;
    end else begin
      sel = valid_i[1];
    end
  end

  assign valid_o = valid_i[sel];
  assign flit_o  = flit_i[sel];
  assign gnt_o   = sel ? {ready_i, 1'b0} : {1'b0, ready_i};

  // A stalled flit also locks, so the output holds still
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q       <= 1'b0;
      locked_q   <= 1'b0;
      lock_idx_q <= 1'b0;
    end else if (valid_o) begin
      locked_q   <= !(ready_i && flit_o.hdr.last);
      lock_idx_q <= sel;
      if (ready_i) begin
        rr_q <= sel;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(flit_o))
    else $error("request flit changed while the NoC stalled");

endmodule

/* test/noc_chimney_vectors.txt */
// op_addr_data_aux, op 1 write, 2 read, 3 write with read inside, 4 B, 5 R
// aux: [15:8] len, [8] R last, [7:4] read id, [5:4] resp, [3:0] id
1_30000100_11110000_0302
2_70000040_00000000_0005
4_00000003_00000000_0012
5_00000007_deadbeef_0105
3_a0000200_50000080_0261
1_f0000000_22220000_0007
2_00000010_00000000_0109
5_00000007_01234567_0009
5_00000007_89abcdef_0129
4_0000000a_00000000_0031
1_60000800_33330000_0708
2_c0000020_00000000_000b
3_20000400_90000100_01c4
5_0000000c_cafef00d_010b

/* test/tb_noc_axi_chimney.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the manager-side AXI to NoC network interface.
// Reads operations from test/noc_chimney_vectors.txt, drives AXI and
// NoC inputs and checks every request flit and AXI response in order.
////////////////////////////////////////////////////////////////////////////

`include "noc_config.svh"

module tb_noc_axi_chimney;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int         TIMEOUT = 500;
  localparam int         MAX_VEC = 32;
  localparam logic [3:0] NODE_ID = 4'h5;

  logic                          clk_i, rst_n_i;
  logic [`NOC_NODE_ID_W-1:0]     node_id_i;
  logic                          aw_valid_i, w_valid_i, ar_valid_i, w_last_i;
  logic [`NOC_ADDR_W-1:0]        aw_addr_i, ar_addr_i;
  logic [`NOC_ID_W-1:0]          aw_id_i, ar_id_i, b_id_o, r_id_o;
  logic [`NOC_LEN_W-1:0]         aw_len_i, ar_len_i;
  logic [`NOC_DATA_W-1:0]        w_data_i, r_data_o;
  logic [`NOC_STRB_W-1:0]        w_strb_i;
  logic                          aw_ready_o, w_ready_o, ar_ready_o;
  logic                          b_valid_o, b_ready_i, r_valid_o, r_ready_i, r_last_o;
  noc_axi_pkg::resp_t            b_resp_o, r_resp_o;
  logic                          req_valid_o, req_ready_i, rsp_valid_i, rsp_ready_o;
  noc_flit_pkg::req_flit_t       req_flit_o, exp_flit;
  noc_flit_pkg::rsp_flit_t       rsp_flit_i;
  noc_axi_pkg::b_chan_t          exp_b_cur;
  noc_axi_pkg::r_chan_t          exp_r_cur;

  logic [83:0]                   vectors [MAX_VEC];
  integer                        seed = 54;
  int                            req_seen;
  noc_flit_pkg::req_flit_t       exp_req[$];
  noc_axi_pkg::b_chan_t          exp_b[$];
  noc_axi_pkg::r_chan_t          exp_r[$];

  noc_axi_chimney dut0 (.*);

  always #10 clk_i = ~clk_i;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("ERROR %s expected %0h actual %0h", name, exp, act);
      fail_run("value mismatch");
    end
  endtask

  function automatic noc_flit_pkg::req_flit_t make_flit(input logic [3:0] dst,
      input logic last, input noc_flit_pkg::axi_ch_e ch, input logic [43:0] payload);
    noc_flit_pkg::req_flit_t f;
    f.hdr.dst_id  = dst;
    f.hdr.src_id  = NODE_ID;
    f.hdr.last    = last;
    f.hdr.ch      = ch;
    f.payload     = payload;
    return f;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Drivers

  task automatic send_aw(input logic [31:0] addr, input logic [3:0] id, input logic [7:0] len);
    int cnt;
    cnt = 0;
    @(posedge clk_i);
    aw_valid_i <= 1'b1;
    aw_addr_i  <= addr;
    aw_id_i    <= id;
    aw_len_i   <= len;
    do begin
      @(posedge clk_i);
      cnt++;
      if (cnt > TIMEOUT) fail_run("timed out waiting for aw_ready_o");
    end while (!aw_ready_o);
    aw_valid_i <= 1'b0;
  endtask

  task automatic send_ar(input logic [31:0] addr, input logic [3:0] id, input logic [7:0] len);
    int cnt;
    cnt = 0;
    @(posedge clk_i);
    ar_valid_i <= 1'b1;
    ar_addr_i  <= addr;
    ar_id_i    <= id;
    ar_len_i   <= len;
    do begin
      @(posedge clk_i);
      cnt++;
      if (cnt > TIMEOUT) fail_run("timed out waiting for ar_ready_o");
    end while (!ar_ready_o);
    ar_valid_i <= 1'b0;
  endtask

  task automatic send_w(input logic [31:0] data, input logic last);
    int cnt;
    cnt = 0;
    @(posedge clk_i);
    w_valid_i <= 1'b1;
    w_data_i  <= data;
    w_last_i  <= last;
    do begin
      @(posedge clk_i);
      cnt++;
      if (cnt > TIMEOUT) fail_run("timed out waiting for w_ready_o");
    end while (!w_ready_o);
    w_valid_i <= 1'b0;
  endtask

  task automatic send_rsp(input noc_flit_pkg::rsp_flit_t flit);
    int cnt;
    cnt = 0;
    @(posedge clk_i);
    rsp_valid_i <= 1'b1;
    rsp_flit_i  <= flit;
    do begin
      @(posedge clk_i);
      cnt++;
      if (cnt > TIMEOUT) fail_run("timed out waiting for rsp_ready_o");
    end while (!rsp_ready_o);
    rsp_valid_i <= 1'b0;
  endtask

  // Expected W beats of one burst, data counts up from base
  task automatic expect_w_beats(input logic [3:0] dst, input logic [31:0] base, input int beats);
    for (int i = 0; i < beats; i++) begin
      exp_req.push_back(make_flit(dst, i == beats - 1, noc_flit_pkg::CH_W,
                                  {7'b0, base + i, 4'hf, i == beats - 1}));
    end
  endtask

  task automatic drive_w_beats(input logic [31:0] base, input int beats);
    for (int i = 0; i < beats; i++) begin
      send_w(base + i, i == beats - 1);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitors and back-pressure

  always @(posedge clk_i) begin
    req_ready_i <= ($random(seed) % 4) != 0;
    r_ready_i   <= ($random(seed) % 3) != 0;
    b_ready_i   <= ($random(seed) % 2) != 0;
  end

  always @(posedge clk_i) begin
    if (rst_n_i && req_valid_o && req_ready_i) begin
      if (exp_req.size() == 0) fail_run("request flit arrived that was not expected");
      exp_flit = exp_req.pop_front();
      check("req dst", 64'(exp_flit.hdr.dst_id), 64'(req_flit_o.hdr.dst_id));
      check("req src", 64'(exp_flit.hdr.src_id), 64'(req_flit_o.hdr.src_id));
      check("req ch", 64'(exp_flit.hdr.ch), 64'(req_flit_o.hdr.ch));
      check("req last", 64'(exp_flit.hdr.last), 64'(req_flit_o.hdr.last));
      check("req payload", 64'(exp_flit.payload), 64'(req_flit_o.payload));
      req_seen++;
    end
    if (rst_n_i && b_valid_o && b_ready_i) begin
      if (exp_b.size() == 0) fail_run("B response arrived that was not expected");
      exp_b_cur = exp_b.pop_front();
      check("b id", 64'(exp_b_cur.id), 64'(b_id_o));
      check("b resp", 64'(exp_b_cur.resp), 64'(b_resp_o));
    end
    if (rst_n_i && r_valid_o && r_ready_i) begin
      if (exp_r.size() == 0) fail_run("R response arrived that was not expected");
      exp_r_cur = exp_r.pop_front();
      check("r id", 64'(exp_r_cur.id), 64'(r_id_o));
      check("r data", 64'(exp_r_cur.data), 64'(r_data_o));
      check("r resp", 64'(exp_r_cur.resp), 64'(r_resp_o));
      check("r last", 64'(exp_r_cur.last), 64'(r_last_o));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    logic [3:0]              op;
    logic [31:0]             a, d;
    logic [15:0]             x;
    int                      beats, target, cnt;
    noc_flit_pkg::rsp_flit_t rf;

    clk_i = 1'b0;
    rst_n_i = 1'b0;
    node_id_i = NODE_ID;
    aw_valid_i = 1'b0;
    w_valid_i = 1'b0;
    ar_valid_i = 1'b0;
    aw_addr_i = '0;
    aw_id_i = '0;
    aw_len_i = '0;
    ar_addr_i = '0;
    ar_id_i = '0;
    ar_len_i = '0;
    w_data_i = '0;
    w_strb_i = '1;
    w_last_i = 1'b0;
    rsp_valid_i = 1'b0;
    rsp_flit_i = '0;
    req_ready_i = 1'b0;
    b_ready_i = 1'b0;
    r_ready_i = 1'b0;
    req_seen = 0;
    for (int i = 0; i < MAX_VEC; i++) vectors[i] = '0;
    $readmemh("test/noc_chimney_vectors.txt", vectors);

    repeat (15) @(posedge clk_i);
    check("reset aw_ready", 64'(0), 64'(aw_ready_o));
    check("reset ar_ready", 64'(0), 64'(ar_ready_o));
    check("reset w_ready", 64'(0), 64'(w_ready_o));
    check("reset rsp_ready", 64'(0), 64'(rsp_ready_o));
    @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    check("reset req_valid", 64'(0), 64'(req_valid_o));
    check("reset b_valid", 64'(0), 64'(b_valid_o));
    check("reset r_valid", 64'(0), 64'(r_valid_o));

    for (int v = 0; v < MAX_VEC && vectors[v][83:80] != 4'h0; v++) begin
      op = vectors[v][83:80];
      a  = vectors[v][79:48];
      d  = vectors[v][47:16];
      x  = vectors[v][15:0];
      beats = int'(x[15:8]) + 1;
      case (op)
        4'h1: begin
          exp_req.push_back(make_flit(a[31:28], 1'b0, noc_flit_pkg::CH_AW, {a, x[3:0], x[15:8]}));
          expect_w_beats(a[31:28], d, beats);
          send_aw(a, x[3:0], x[15:8]);
          drive_w_beats(d, beats);
        end
        4'h2: begin
          exp_req.push_back(make_flit(a[31:28], 1'b1, noc_flit_pkg::CH_AR, {a, x[3:0], x[15:8]}));
          send_ar(a, x[3:0], x[15:8]);
        end
        4'h3: begin
          // AR issued once the AW flit is out, so it must trail the burst
          target = req_seen + exp_req.size() + 1;
          exp_req.push_back(make_flit(a[31:28], 1'b0, noc_flit_pkg::CH_AW, {a, x[3:0], x[15:8]}));
          expect_w_beats(a[31:28], 32'hc0de0000, beats);
          exp_req.push_back(make_flit(d[31:28], 1'b1, noc_flit_pkg::CH_AR, {d, x[7:4], 8'h00}));
          send_aw(a, x[3:0], x[15:8]);
          cnt = 0;
          while (req_seen < target) begin
            @(posedge clk_i);
            cnt++;
            if (cnt > TIMEOUT) fail_run("timed out waiting for the AW flit on the NoC");
          end
          send_ar(d, x[7:4], 8'h00);
          drive_w_beats(32'hc0de0000, beats);
        end
        4'h4: begin
          exp_b.push_back('{id: x[3:0], resp: x[5:4]});
          rf.hdr.dst_id = NODE_ID;
          rf.hdr.src_id = a[3:0];
          rf.hdr.last = 1'b1;
          rf.hdr.ch = noc_flit_pkg::CH_B;
          rf.payload = {33'b0, x[3:0], x[5:4]};
          send_rsp(rf);
        end
        4'h5: begin
          exp_r.push_back('{id: x[3:0], data: d, resp: x[5:4], last: x[8]});
          rf.hdr.dst_id = NODE_ID;
          rf.hdr.src_id = a[3:0];
          rf.hdr.last = x[8];
          rf.hdr.ch = noc_flit_pkg::CH_R;
          rf.payload = {x[3:0], d, x[5:4], x[8]};
          send_rsp(rf);
        end
        default: fail_run("unknown operation code in the vector file");
      endcase
    end

    cnt = 0;
    while ((exp_req.size() + exp_b.size() + exp_r.size()) != 0 && cnt <= TIMEOUT) begin
      @(posedge clk_i);
      cnt++;
    end
    if ((exp_req.size() + exp_b.size() + exp_r.size()) == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("expected flits or responses never arrived");
      $display("TEST RESULT: FAIL");
      $fatal(1, "run stopped");
    end
  end

endmodule
